// ==== fused_top.f ====
+incdir+src
src/mem_pkg.sv
src/conv_pkg.sv
src/global_buffer.sv
src/fetch_sequencer.sv
src/pointwise_layer.sv
src/result_writer.sv
src/fused_top.sv
verification/fused_checker.sv
verification/tb_fused_top.sv

// ==== Makefile ====
TOP = tb_fused_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f fused_top.f -o vsim
	@out="$$(./obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== verification/tb_fused_top.sv ====
`timescale 1ns/1ps

module tb_fused_top
    import mem_pkg::*;
    import conv_pkg::*;
();

    localparam int NUM_TESTS = 7;
    localparam int CLK_HALF  = 20;

    // Mixed small weights
    localparam weight_word_t W_A = 128'h0CF41A07_E91503F8_220DF109_05EE170B;
    localparam weight_word_t W_B = 128'h1106F31C_08E50F02_F7190AEC_1304FD1E;
    localparam weight_word_t W_C = 128'h3AC5127F_8024E019_055BA30E_F03367C8;
    localparam weight_word_t W_D = 128'h07090B0D_F9F7F5F3_20E010F0_01020304;
    localparam weight_word_t W_E = 128'h1F2E3D4C_5B6A7988_97A6B5C4_D3E2F100;
    localparam weight_word_t W_F = 128'hF00FE11E_D22DC33C_B44BA55A_96698778;
    // Filters 0 and 1 at +127, filters 2 and 3 at -128
    localparam weight_word_t W_SAT = 128'h80808080_80808080_7F7F7F7F_7F7F7F7F;

    typedef enum int {DATA_RANDOM, DATA_POS, DATA_NEG} data_mode_t;

    typedef struct packed {
        buf_addr_t    word_count;
        buf_addr_t    weight_base;
        buf_addr_t    ifm_base;
        buf_addr_t    ofm_base;
        weight_word_t w1;
        weight_word_t w2;
        data_mode_t   mode;
        bit           busy_start;   // Pulse start again mid-run
    } test_t;

    test_t     tests [NUM_TESTS];
    logic      table_ready;

    logic      clk;
    logic      reset;
    logic      load_phase;
    logic      host_we;
    logic      start;
    buf_addr_t host_addr;
    buf_word_t host_wdata;
    buf_word_t host_rdata;
    buf_addr_t weight_base;
    buf_addr_t ifm_base;
    buf_addr_t ofm_base;
    buf_addr_t word_count;
    logic      busy;
    logic      done;
    int        test_idx;
    logic      test_end;
    logic      run_end;
    int        error_count;

    fused_top dut (
        .clk(clk), .reset(reset), .load_phase(load_phase), .host_we(host_we),
        .start(start), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .weight_base(weight_base), .ifm_base(ifm_base),
        .ofm_base(ofm_base), .word_count(word_count), .busy(busy), .done(done)
    );

    fused_checker u_checker (
        .clk(clk), .reset(reset), .load_phase(load_phase), .start(start),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .weight_base(weight_base), .ifm_base(ifm_base),
        .ofm_base(ofm_base), .word_count(word_count), .busy(busy), .done(done),
        .test_idx(test_idx), .test_end(test_end), .run_end(run_end),
        .error_count(error_count)
    );

    always #CLK_HALF clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #2;                                  // Drive just after the edge
    endtask

    task automatic host_write(buf_addr_t addr, buf_word_t data);
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        next_cycle();
    endtask

    task automatic host_read(buf_addr_t addr);
        host_we   = 1'b0;
        host_addr = addr;
        next_cycle();
    endtask

    function automatic buf_word_t input_word(data_mode_t mode);
        buf_word_t word;
        for (int b = 0; b < 16; b++) begin
            case (mode)
                DATA_POS: word[b*8 +: 8] = 8'd96 + 8'($urandom % 32);   // 96 to 127
                DATA_NEG: word[b*8 +: 8] = 8'h80 + 8'($urandom % 32);   // -128 to -97
                default:  word[b*8 +: 8] = 8'($urandom);
            endcase
        end
        return word;
    endfunction

    function automatic buf_word_t fill_word(buf_addr_t addr);
        return {16{addr}} ^ 128'hC3A55A3C_96F00F69_1EE1D22D_B44B7887;
    endfunction

    task automatic run_one(int t);
        test_t tc;
        tc          = tests[t];
        test_idx    = t;
        weight_base = tc.weight_base;
        ifm_base    = tc.ifm_base;
        ofm_base    = tc.ofm_base;
        word_count  = tc.word_count;
        load_phase  = 1'b1;
        host_write(tc.weight_base, tc.w1);
        host_write(tc.weight_base + 8'd1, tc.w2);
        for (int w = 0; w < int'(tc.word_count); w++) begin
            host_write(tc.ifm_base + 8'(w), input_word(tc.mode));
        end
        for (int w = 0; w <= int'(tc.word_count); w++) begin   // One guard word past the end
            host_write(tc.ofm_base + 8'(w), fill_word(tc.ofm_base + 8'(w)));
        end
        host_we    = 1'b0;
        load_phase = 1'b0;
        start      = 1'b1;
        next_cycle();
        start = 1'b0;
        if (tc.busy_start) begin
            repeat (12) next_cycle();        // After the first word is written
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        while (done !== 1'b1) begin
            next_cycle();
        end
        next_cycle();
        load_phase = 1'b1;
        host_read(tc.weight_base);
        host_read(tc.weight_base + 8'd1);
        for (int w = 0; w < int'(tc.word_count); w++) begin
            host_read(tc.ifm_base + 8'(w));
        end
        for (int w = 0; w <= int'(tc.word_count); w++) begin
            host_read(tc.ofm_base + 8'(w));
        end
        repeat (2) next_cycle();             // Let the last read come back
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        void'($urandom(74595));
        clk         = 1'b0;
        reset       = 1'b1;
        load_phase  = 1'b0;
        host_we     = 1'b0;
        start       = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        weight_base = '0;
        ifm_base    = '0;
        ofm_base    = '0;
        word_count  = '0;
        test_idx    = 0;
        test_end    = 1'b0;
        run_end     = 1'b0;
        // word_count, weight_base, ifm_base, ofm_base, w1, w2, mode, busy_start
        tests[0] = '{8'd1, 8'd0,  8'd4,  8'd64,  W_A,   W_B,   DATA_RANDOM, 1'b0};
        tests[1] = '{8'd3, 8'd16, 8'd20, 8'd80,  W_C,   W_D,   DATA_RANDOM, 1'b0};
        tests[2] = '{8'd8, 8'd32, 8'd40, 8'd96,  W_E,   W_F,   DATA_RANDOM, 1'b0};
        tests[3] = '{8'd4, 8'd48, 8'd50, 8'd112, W_SAT, W_SAT, DATA_POS,    1'b0};
        tests[4] = '{8'd4, 8'd48, 8'd56, 8'd120, W_SAT, W_SAT, DATA_NEG,    1'b0};
        tests[5] = '{8'd3, 8'd0,  8'd4,  8'd64,  W_C,   W_B,   DATA_RANDOM, 1'b1};
        tests[6] = '{8'd3, 8'd0,  8'd4,  8'd64,  W_A,   W_D,   DATA_RANDOM, 1'b0};
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_one(t);
        end
        run_end = 1'b1;
        next_cycle();
        run_end = 1'b0;
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        longint limit;
        wait (table_ready === 1'b1);
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += 200 * int'(tests[t].word_count) + 500;
        end
        #(limit * 2 * CLK_HALF);
        $display("The run timed out after %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verification/fused_checker.sv ====
`timescale 1ns/1ps
`include "fused_cfg.svh"

module fused_checker
    import mem_pkg::*;
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_phase,
    input  logic      start,
    input  logic      host_we,
    input  buf_addr_t host_addr,
    input  buf_word_t host_wdata,
    input  buf_word_t host_rdata,
    input  buf_addr_t weight_base,
    input  buf_addr_t ifm_base,
    input  buf_addr_t ofm_base,
    input  buf_addr_t word_count,
    input  logic      busy,
    input  logic      done,
    input  int        test_idx,
    input  logic      test_end,
    input  logic      run_end,
    output int        error_count
);

    buf_word_t model [`BUF_DEPTH];  // Expected buffer contents
    logic      rd_pend;             // Host read issued last cycle
    buf_addr_t rd_addr_q;
    logic      reset_q;
    logic      done_q;
    logic      running;
    int        done_seen;
    int        checks;
    int        errors_before;       // Error count when the test began
    int        tests_run;
    int        tests_failed;

    // One 1x1 layer of four filters on one pixel
    function automatic pixel_t conv_pixel(pixel_t px, weight_word_t wt, bit relu);
        int     acc;
        int     lo;
        int     hi;
        pixel_t res;
        lo = relu ? 0 : -128;
        hi = relu ? `RELU6_MAX : 127;
        for (int f = 0; f < `CH; f++) begin
            acc = 0;
            for (int c = 0; c < `CH; c++) begin
                acc += int'($signed(px[c*8 +: 8])) * int'($signed(wt[(f*`CH + c)*8 +: 8]));
            end
            acc = acc >>> (relu ? `L1_SHIFT : `L2_SHIFT);
            if (acc < lo) begin
                acc = lo;
            end else if (acc > hi) begin
                acc = hi;
            end
            res[f*8 +: 8] = acc[7:0];
        end
        return res;
    endfunction

    // Output region as the fused layers should leave it
    task automatic apply_model();
        buf_word_t in_word;
        buf_word_t out_word;
        pixel_t    mid;
        for (int w = 0; w < int'(word_count); w++) begin
            in_word = model[ifm_base + buf_addr_t'(w)];
            for (int p = 0; p < `PIX_PER_WORD; p++) begin
                mid = conv_pixel(in_word[p*32 +: 32], model[weight_base], 1'b1);
                out_word[p*32 +: 32] = conv_pixel(mid, model[weight_base + 8'd1], 1'b0);
            end
            model[ofm_base + buf_addr_t'(w)] = out_word;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            rd_pend       = 1'b0;
            reset_q       = 1'b1;
            done_q        = 1'b0;
            running       = 1'b0;
            done_seen     = 0;
            checks        = 0;
            errors_before = 0;
            tests_run     = 0;
            tests_failed  = 0;
            error_count   = 0;
        end else begin
            if (reset_q && (busy || done)) begin
                $display("Error at %0d ns: busy or done high after reset", $time);
                error_count++;
            end
            reset_q = 1'b0;
            if (rd_pend) begin            // Data for last cycle's address
                checks++;
                if (host_rdata !== model[rd_addr_q]) begin
                    $display("Error at %0d ns: word %0d read %h, expected %h",
                             $time, rd_addr_q, host_rdata, model[rd_addr_q]);
                    error_count++;
                end
            end
            rd_pend   = load_phase && !host_we;
            rd_addr_q = host_addr;
            if (load_phase && host_we) begin
                model[host_addr] = host_wdata;
            end
            if (done && done_q) begin
                $display("Done stayed high for more than one cycle at %0d ns", $time);
                error_count++;
            end
            if (running) begin
                if (done) begin
                    if (busy) begin
                        $display("Busy still high during done at %0d ns", $time);
                        error_count++;
                    end
                    running = 1'b0;
                    done_seen++;
                    apply_model();
                end else if (!busy) begin
                    $display("Busy dropped before done at %0d ns", $time);
                    error_count++;
                end
            end else if (done) begin
                done_seen++;
                $display("Done arrived without a started run at %0d ns", $time);
                error_count++;
            end else if (busy) begin
                $display("Busy high with no run in progress at %0d ns", $time);
                error_count++;
            end else if (start && !load_phase && !busy) begin
                running = 1'b1;
            end
            done_q = done;
            if (test_end) begin
                tests_run++;
                if (done_seen != 1) begin
                    $display("Test %0d saw %0d done pulses instead of one", test_idx, done_seen);
                    error_count++;
                end
                if (error_count == errors_before) begin
                    $display("Test %0d passed, %0d words", test_idx, word_count);
                end else begin
                    tests_failed++;
                    $display("Test %0d failed with %0d errors", test_idx,
                             error_count - errors_before);
                end
                errors_before = error_count;
                done_seen     = 0;
            end
            if (run_end) begin
                $display("Tests run %0d, passed %0d, failed %0d, reads checked %0d, errors %0d",
                         tests_run, tests_run - tests_failed, tests_failed, checks, error_count);
            end
        end
    end

endmodule

// ==== src/fused_top.sv ====
`timescale 1ns/1ps

module fused_top
    import mem_pkg::*;
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_phase,
    input  logic      host_we,
    input  logic      start,
    input  buf_addr_t host_addr,
    input  buf_word_t host_wdata,
    output buf_word_t host_rdata,
    input  buf_addr_t weight_base,
    input  buf_addr_t ifm_base,
    input  buf_addr_t ofm_base,
    input  buf_addr_t word_count,
    output logic      busy,
    output logic      done
);

    logic         start_ok;

    logic         rd_req;
    logic         rd_gnt;
    buf_addr_t    rd_addr;
    buf_word_t    rd_data;
    logic         wr_req;
    logic         wr_gnt;
    buf_addr_t    wr_addr;
    buf_word_t    wr_data;

    weight_word_t w1;
    weight_word_t w2;
    pixel_t       pix;
    logic         pix_valid;
    pixel_t       l1_pix;
    logic         l1_valid;
    pixel_t       l2_pix;
    logic         l2_valid;

    assign start_ok = start && !load_phase && !busy;   // Only from idle, outside load

    global_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .load_phase (load_phase),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_gnt     (rd_gnt),
        .rd_data    (rd_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_gnt     (wr_gnt)
    );

    fetch_sequencer u_fetch (
        .clk         (clk),
        .reset       (reset),
        .start       (start_ok),
        .done        (done),
        .weight_base (weight_base),
        .ifm_base    (ifm_base),
        .word_count  (word_count),
        .busy        (busy),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_gnt      (rd_gnt),
        .rd_data     (rd_data),
        .w1          (w1),
        .w2          (w2),
        .pix         (pix),
        .pix_valid   (pix_valid)
    );

    pointwise_layer #(.relu_en(1'b1)) layer1 (
        .clk       (clk),
        .reset     (reset),
        .weights   (w1),
        .in_pix    (pix),
        .in_valid  (pix_valid),
        .out_pix   (l1_pix),
        .out_valid (l1_valid)
    );

    pointwise_layer #(.relu_en(1'b0)) layer2 (
        .clk       (clk),
        .reset     (reset),
        .weights   (w2),
        .in_pix    (l1_pix),
        .in_valid  (l1_valid),
        .out_pix   (l2_pix),
        .out_valid (l2_valid)
    );

    result_writer u_writer (
        .clk        (clk),
        .reset      (reset),
        .start      (start_ok),
        .ofm_base   (ofm_base),
        .word_count (word_count),
        .in_pix     (l2_pix),
        .in_valid   (l2_valid),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_gnt     (wr_gnt),
        .done       (done)
    );

endmodule

// ==== src/result_writer.sv ====
`timescale 1ns/1ps
`include "fused_cfg.svh"

module result_writer
    import mem_pkg::*;
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  buf_addr_t ofm_base,
    input  buf_addr_t word_count,
    input  pixel_t    in_pix,
    input  logic      in_valid,
    output logic      wr_req,
    output buf_addr_t wr_addr,
    output buf_word_t wr_data,
    input  logic      wr_gnt,
    output logic      done
);

    localparam int PIX_W = $bits(pixel_t);
    localparam int IDX_W = $clog2(`PIX_PER_WORD);
    localparam logic [IDX_W-1:0] PIX_LAST = IDX_W'(`PIX_PER_WORD - 1);

    logic [IDX_W-1:0] pix_cnt;     // Slot of the next pixel
    buf_addr_t        word_idx;    // Words written so far
    logic             last_word;

    assign last_word = (word_idx == word_count - 1'b1);

    always_ff @(posedge clk) begin
        if (reset || start) begin
            pix_cnt  <= '0;
            word_idx <= '0;
            wr_req   <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (in_valid) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == PIX_LAST) begin
                    wr_req <= 1'b1;          // Word full
                end
            end
            if (wr_req && wr_gnt) begin
                wr_req   <= 1'b0;
                word_idx <= word_idx + 1'b1;
                done     <= last_word;       // One-cycle pulse after final write
            end
        end
    end

    // Write happens at the same edge a new slot 0 could land
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_data[pix_cnt*PIX_W +: PIX_W] <= in_pix;
            if (pix_cnt == PIX_LAST) begin
                wr_addr <= ofm_base + word_idx;
            end
        end
    end

endmodule

// ==== src/pointwise_layer.sv ====
`timescale 1ns/1ps
`include "fused_cfg.svh"

module pointwise_layer
    import conv_pkg::*;
#(
    parameter bit relu_en = 1'b1
) (
    input  logic         clk,
    input  logic         reset,
    input  weight_word_t weights,
    input  pixel_t       in_pix,
    input  logic         in_valid,
    output pixel_t       out_pix,
    output logic         out_valid
);

    localparam int   SHIFT    = relu_en ? `L1_SHIFT : `L2_SHIFT;
    localparam acc_t CLAMP_LO = relu_en ? acc_t'(0) : acc_t'(-128);
    localparam acc_t CLAMP_HI = relu_en ? acc_t'(`RELU6_MAX) : acc_t'(127);

    act_t   in_ch  [`CH];
    act_t   wt     [`CH][`CH];
    acc_t   sum    [`CH];
    acc_t   scaled [`CH];
    pixel_t result;

    // Unpack channels and the 4x4 weight matrix
    always_comb begin
        for (int c = 0; c < `CH; c++) begin
            in_ch[c] = in_pix[c*`ACT_W +: `ACT_W];
        end
        for (int f = 0; f < `CH; f++) begin
            for (int c = 0; c < `CH; c++) begin
                wt[f][c] = weights[(f*`CH + c)*`ACT_W +: `ACT_W];
            end
        end
    end

    always_comb begin
        for (int f = 0; f < `CH; f++) begin
            sum[f] = '0;
            for (int c = 0; c < `CH; c++) begin
                sum[f] = sum[f] + in_ch[c] * wt[f][c];   // Signed MAC at 20 bits
            end
            scaled[f] = sum[f] >>> SHIFT;
            if (scaled[f] < CLAMP_LO) begin
                result[f*`ACT_W +: `ACT_W] = CLAMP_LO[`ACT_W-1:0];
            end else if (scaled[f] > CLAMP_HI) begin
                result[f*`ACT_W +: `ACT_W] = CLAMP_HI[`ACT_W-1:0];
            end else begin
                result[f*`ACT_W +: `ACT_W] = scaled[f][`ACT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_pix <= result;
        end
    end

endmodule

// ==== src/fetch_sequencer.sv ====
`timescale 1ns/1ps
`include "fused_cfg.svh"

module fetch_sequencer
    import mem_pkg::*;
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic         done,
    input  buf_addr_t    weight_base,
    input  buf_addr_t    ifm_base,
    input  buf_addr_t    word_count,
    output logic         busy,
    output logic         rd_req,
    output buf_addr_t    rd_addr,
    input  logic         rd_gnt,
    input  buf_word_t    rd_data,
    output weight_word_t w1,
    output weight_word_t w2,
    output pixel_t       pix,
    output logic         pix_valid
);

    localparam int PIX_W   = $bits(pixel_t);
    localparam int IDX_W   = $clog2(`PIX_PER_WORD);
    localparam logic [IDX_W-1:0] PIX_LAST = IDX_W'(`PIX_PER_WORD - 1);

    seq_state_t       state;
    buf_addr_t        word_idx;
    logic [IDX_W-1:0] pix_idx;
    logic             rd_vld;      // Read data from last cycle's grant
    logic             last_word;
    buf_word_t        ifm_word;

    assign last_word = (word_idx == word_count - 1'b1);
    assign busy      = (state != IDLE) && !done;   // Drops with done
    assign pix_valid = (state == STREAM);
    assign pix       = ifm_word[pix_idx*PIX_W +: PIX_W];

    always_comb begin
        rd_req  = 1'b0;
        rd_addr = ifm_base + word_idx;
        case (state)
            W1_RD: begin
                rd_req  = 1'b1;
                rd_addr = weight_base;
            end
            W2_RD: begin
                rd_req  = 1'b1;
                rd_addr = weight_base + 1'b1;
            end
            IFM_RD: begin
                rd_req  = 1'b1;
            end
            default: begin
                rd_req  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            word_idx <= '0;
            pix_idx  <= '0;
            rd_vld   <= 1'b0;
        end else begin
            rd_vld <= rd_req && rd_gnt;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= W1_RD;
                        word_idx <= '0;
                        pix_idx  <= '0;
                    end
                end
                W1_RD:    if (rd_gnt) state <= W2_RD;
                W2_RD:    if (rd_gnt) state <= IFM_RD;
                IFM_RD:   if (rd_gnt) state <= IFM_WAIT;   // Refused cycles hold the request
                IFM_WAIT: state <= STREAM;
                STREAM: begin
                    pix_idx <= pix_idx + 1'b1;
                    if (pix_idx == PIX_LAST) begin
                        word_idx <= word_idx + 1'b1;
                        state    <= last_word ? DRAIN : IFM_RD;
                    end
                end
                DRAIN: begin
                    if (done) begin
                        // busy is already low here, so a start may arrive
                        state    <= start ? W1_RD : IDLE;
                        word_idx <= '0;
                        pix_idx  <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Capture target follows from the state after each grant
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            case (state)
                W2_RD:    w1       <= rd_data;
                IFM_RD:   w2       <= rd_data;
                IFM_WAIT: ifm_word <= rd_data;
                default:  ;
            endcase
        end
    end

endmodule

// ==== src/global_buffer.sv ====
`timescale 1ns/1ps
`include "fused_cfg.svh"

module global_buffer
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_phase,
    input  logic      host_we,
    input  buf_addr_t host_addr,
    input  buf_word_t host_wdata,
    output buf_word_t host_rdata,
    input  logic      rd_req,
    input  buf_addr_t rd_addr,
    output logic      rd_gnt,
    output buf_word_t rd_data,
    input  logic      wr_req,
    input  buf_addr_t wr_addr,
    input  buf_word_t wr_data,
    output logic      wr_gnt
);

    buf_word_t mem [`BUF_DEPTH];

    buf_addr_t port_addr;
    buf_word_t port_wdata;
    logic      port_we;
    logic      port_re;
    buf_word_t port_q;      // Single read register for all peers

    // Host owns the port during load, then writer over fetcher
    assign wr_gnt = !load_phase && wr_req;
    assign rd_gnt = !load_phase && rd_req && !wr_req;

    always_comb begin
        if (load_phase) begin
            port_addr  = host_addr;
            port_wdata = host_wdata;
            port_we    = host_we;
            port_re    = !host_we;           // Host read back
        end else if (wr_req) begin
            port_addr  = wr_addr;
            port_wdata = wr_data;
            port_we    = 1'b1;
            port_re    = 1'b0;
        end else begin
            port_addr  = rd_addr;
            port_wdata = wr_data;
            port_we    = 1'b0;
            port_re    = rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (port_we) begin
            mem[port_addr] <= port_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            port_q <= '0;
        end else if (port_re) begin
            port_q <= mem[port_addr];       // Valid the cycle after the grant
        end
    end

    assign host_rdata = port_q;
    assign rd_data    = port_q;

endmodule

// ==== src/conv_pkg.sv ====
`include "fused_cfg.svh"

package conv_pkg;

    typedef logic signed [`ACT_W-1:0] act_t;

    // Channel c in byte c
    typedef logic [`CH*`ACT_W-1:0] pixel_t;

    // Filter f, channel c in byte 4f+c
    typedef logic [`CH*`CH*`ACT_W-1:0] weight_word_t;

    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef enum logic [2:0] {
        IDLE,
        W1_RD,     // Layer 1 weight word
        W2_RD,     // Layer 2 weight word
        IFM_RD,
        IFM_WAIT,
        STREAM,    // One pixel per cycle
        DRAIN      // Wait for last write
    } seq_state_t;

endpackage

// ==== src/mem_pkg.sv ====
`include "fused_cfg.svh"

package mem_pkg;

    // Buffer word, holds four pixels or one layer's weights
    typedef logic [`WORD_W-1:0] buf_word_t;

    typedef logic [`ADDR_W-1:0] buf_addr_t;  // Word address, no byte offset

endpackage

// ==== src/fused_cfg.svh ====
`ifndef FUSED_CFG_SVH
`define FUSED_CFG_SVH

// Global buffer geometry
`define WORD_W        128
`define ADDR_W        8
`define BUF_DEPTH     256

// Datapath widths
`define ACT_W         8    // One int8 channel value
`define ACC_W         20   // Dot-product accumulator
`define CH            4    // Channels, also filters per layer
`define PIX_PER_WORD  4

// Requantization shifts per layer
`define L1_SHIFT      4
`define L2_SHIFT      4

// Six in Q4 fixed point
`define RELU6_MAX     96

`endif
